// ==== logic/arcade_consts.svh ====
// ####################
// Download region map, PROM size
// and ROM slot address/data widths
// ####################
`ifndef ARCADE_CONSTS_SVH
`define ARCADE_CONSTS_SVH

// Byte addresses in the download stream
`define MAIN_BASE    25'h00_0000
`define CHAR_BASE    25'h08_0000
`define OBJ_BASE     25'h0D_0000
`define PROM_BASE    25'h19_0000
`define PROM_SIZE    25'h00_0200

// Slot offsets in 16-bit SDRAM words
`define MAIN_OFFSET  22'(`MAIN_BASE >> 1)
`define CHAR_OFFSET  22'(`CHAR_BASE >> 1)
`define OBJ_OFFSET   22'(`OBJ_BASE >> 1)

// Slot shapes
`define MAIN_AW      18
`define MAIN_DW      8
`define CHAR_AW      16
`define CHAR_DW      8
`define OBJ_AW       19     // Half-word address
`define OBJ_DW       16

`endif

// ==== logic/arcade_pkg.sv ====
// ####################
// Vector types for the ROM path
// and the arbiter state encoding
// ####################
`include "arcade_consts.svh"

package arcade_pkg;

    typedef logic [7:0]  byte_t;        // Download byte, 8-bit ROM data
    typedef logic [15:0] half_t;        // One SDRAM word
    typedef logic [31:0] sdram_word_t;  // Burst of two words, even one low
    typedef logic [21:0] sdram_addr_t;  // In 16-bit words
    typedef logic [24:0] ioctl_addr_t;
    // Set bit means that byte lane is left untouched
    typedef logic [1:0]  prog_mask_t;

    typedef logic [`MAIN_AW-1:0] main_addr_t;
    typedef logic [`CHAR_AW-1:0] char_addr_t;
    typedef logic [`OBJ_AW-1:0]  obj_addr_t;

    typedef enum logic [1:0] {
        ARB_IDLE      = 2'd0,
        ARB_WAIT_ACK  = 2'd1,
        ARB_WAIT_DATA = 2'd2
    } arb_state_t;

endpackage

// ==== logic/cen_gen.sv ====
// ####################
// Pixel clock enables from the
// 48 MHz system clock
// ####################
`timescale 1ns/1ps

module cen_gen (
    input  logic clk,
    input  logic rst_n,
    output logic pxl2_cen,
    output logic pxl_cen
);

    logic [2:0] cnt;

    // Free running divide by eight
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= 3'd0;
            pxl2_cen <= 1'b0;
            pxl_cen  <= 1'b0;
        end else begin
            cnt      <= cnt + 3'd1;
            // Phase 2 puts the first pulse in the fourth cycle out of reset
            pxl2_cen <= cnt[1:0] == 2'd2;
            pxl_cen  <= cnt == 3'd6;      // Every other pxl2_cen
        end
    end

endmodule

// ==== logic/rom_download.sv ====
// ####################
// ROM download mapper
// Byte stream to SDRAM writes
// and priority PROM write pulses
// ####################
`timescale 1ns/1ps
`include "arcade_consts.svh"

module rom_download import arcade_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_data,
    input  logic        sdram_ack,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output prog_mask_t  prog_mask,
    output logic        prog_we,
    output logic        prom_we
);

    ioctl_addr_t prom_offset;
    logic        wr_sdram;
    logic        wr_prom;

    // Below the PROM base the offset wraps to a huge value
    assign prom_offset = ioctl_addr - `PROM_BASE;

    // All game ROM regions sit below the PROM
    assign wr_sdram = downloading && ioctl_wr && (ioctl_addr < `PROM_BASE);
    assign wr_prom  = downloading && ioctl_wr && (prom_offset < `PROM_SIZE);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_prom;      // Single cycle strobe
            if (wr_sdram) begin
                prog_we <= 1'b1;
            end else if (prog_we && sdram_ack) begin
                prog_we <= 1'b0;     // Write taken by the SDRAM
            end
        end
    end

    // Write payload, kept stable while prog_we is up
    always_ff @(posedge clk) begin
        if (wr_sdram) begin
            prog_addr <= ioctl_addr[22:1];
            prog_data <= ioctl_data;
            // Even byte goes to the low lane
            prog_mask <= ioctl_addr[0] ? 2'b01 : 2'b10;
        end else if (wr_prom) begin
            prog_addr <= sdram_addr_t'(prom_offset);  // Offset inside the PROM
            prog_data <= ioctl_data;
            prog_mask <= 2'b11;
        end
    end

endmodule

// ==== logic/rom_slot.sv ====
// ####################
// ROM read slot
// One cached SDRAM burst with tag,
// miss request and byte/half select
// ####################
`timescale 1ns/1ps

module rom_slot import arcade_pkg::*; #(
    parameter int          AW     = 18,
    parameter int          DW     = 8,    // 8 or 16
    parameter sdram_addr_t OFFSET = '0    // Region start in words
) (
    input  logic          clk,
    input  logic          rst_n,
    input  logic          downloading,
    input  logic          cs,
    input  logic [AW-1:0] addr,
    input  logic          fill,
    input  sdram_word_t   fill_data,
    output logic          ok,
    output logic [DW-1:0] data,
    output logic          req,
    output sdram_addr_t   req_addr
);

    // Address bits that select inside one 32-bit burst
    localparam int SEL = (DW == 8) ? 2 : 1;
    localparam int TW  = AW - SEL;

    sdram_word_t   cache;
    logic [TW-1:0] tag;
    logic [TW-1:0] pend_tag;   // Tag of the burst being fetched
    logic          valid;
    logic          hit;
    logic          miss;
    sdram_addr_t   word_addr;
    half_t         half_sel;

    assign hit  = valid && (tag == addr[AW-1:SEL]);
    assign ok   = cs && hit;
    assign miss = cs && !hit && !req;

    // Word index plus region offset
    assign word_addr = OFFSET + sdram_addr_t'(addr >> (SEL - 1));

    always_ff @(posedge clk) begin
        if (!rst_n || downloading) begin
            valid <= 1'b0;     // ROM contents are changing
            req   <= 1'b0;
        end else if (req && fill) begin
            valid <= 1'b1;
            req   <= 1'b0;
        end else if (miss) begin
            req   <= 1'b1;     // Held until the fill arrives
        end
    end

    always_ff @(posedge clk) begin
        if (miss) begin
            pend_tag <= addr[AW-1:SEL];
            req_addr <= {word_addr[21:1], 1'b0};  // Burst start
        end
        if (req && fill) begin
            cache <= fill_data;
            tag   <= pend_tag;
        end
    end

    assign half_sel = addr[SEL-1] ? cache[31:16] : cache[15:0];

    generate
        if (DW == 8) begin : g_byte
            assign data = addr[0] ? half_sel[15:8] : half_sel[7:0];
        end else begin : g_half
            assign data = half_sel;
        end
    endgenerate

endmodule

// ==== logic/rom_arbiter.sv ====
// ####################
// SDRAM read arbiter
// Fixed priority main, object, char
// ####################
`timescale 1ns/1ps

module rom_arbiter import arcade_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        downloading,
    input  logic [2:0]  req,             // {char, obj, main}
    input  sdram_addr_t req_addr_main,
    input  sdram_addr_t req_addr_obj,
    input  sdram_addr_t req_addr_char,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_word_t data_read,
    output logic [2:0]  fill,
    output sdram_word_t fill_data,
    output logic        sdram_req,
    output sdram_addr_t sdram_addr
);

    arb_state_t state;
    logic [2:0] grant;
    logic [2:0] pending;
    logic       start;

    // A slot being filled still shows req for this one cycle
    assign pending   = req & ~fill;
    assign start     = (state == ARB_IDLE) && !downloading && (|pending);
    assign sdram_req = state == ARB_WAIT_ACK;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= ARB_IDLE;
            fill  <= 3'b000;
        end else begin
            fill <= 3'b000;
            case (state)
                ARB_IDLE: begin
                    if (start) begin
                        state <= ARB_WAIT_ACK;
                    end
                end
                ARB_WAIT_ACK: begin
                    if (sdram_ack) begin
                        state <= ARB_WAIT_DATA;
                    end
                end
                ARB_WAIT_DATA: begin
                    if (data_rdy) begin
                        fill  <= grant;    // Pulse to the owner
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    // Grant and address stay put until data_rdy
    always_ff @(posedge clk) begin
        if (start) begin
            if (pending[0]) begin
                grant      <= 3'b001;
                sdram_addr <= req_addr_main;
            end else if (pending[1]) begin
                grant      <= 3'b010;
                sdram_addr <= req_addr_obj;
            end else begin
                grant      <= 3'b100;
                sdram_addr <= req_addr_char;
            end
        end
        if (state == ARB_WAIT_DATA && data_rdy) begin
            fill_data <= data_read;
        end
    end

endmodule

// ==== logic/arcade_rom_top.sv ====
// ####################
// ROM side of the game top level
// Clock enables, download mapper,
// three ROM slots and the arbiter
// ####################
`timescale 1ns/1ps
`include "arcade_consts.svh"

module arcade_rom_top import arcade_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    // ROM download
    input  logic        downloading,
    input  logic        ioctl_wr,
    input  ioctl_addr_t ioctl_addr,
    input  byte_t       ioctl_data,
    output sdram_addr_t prog_addr,
    output byte_t       prog_data,
    output prog_mask_t  prog_mask,
    output logic        prog_we,
    output logic        prom_we,
    // SDRAM read port
    output logic        sdram_req,
    output sdram_addr_t sdram_addr,
    input  logic        sdram_ack,
    input  logic        data_rdy,
    input  sdram_word_t data_read,
    output logic        pxl2_cen,
    output logic        pxl_cen,
    // ROM slots
    input  logic        main_cs,
    input  main_addr_t  main_addr,
    output byte_t       main_data,
    output logic        main_ok,
    input  logic        char_cs,
    input  char_addr_t  char_addr,
    output byte_t       char_data,
    output logic        char_ok,
    input  logic        obj_cs,
    input  obj_addr_t   obj_addr,
    output half_t       obj_data,
    output logic        obj_ok
);

    logic [2:0]  slot_req;    // Bit 0 main, 1 obj, 2 char
    logic [2:0]  slot_fill;
    sdram_word_t fill_data;
    sdram_addr_t req_addr_main;
    sdram_addr_t req_addr_obj;
    sdram_addr_t req_addr_char;

    cen_gen cen_gen_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl2_cen (pxl2_cen),
        .pxl_cen  (pxl_cen)
    );

    rom_download rom_download_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .downloading (downloading),
        .ioctl_wr    (ioctl_wr),
        .ioctl_addr  (ioctl_addr),
        .ioctl_data  (ioctl_data),
        .sdram_ack   (sdram_ack),
        .prog_addr   (prog_addr),
        .prog_data   (prog_data),
        .prog_mask   (prog_mask),
        .prog_we     (prog_we),
        .prom_we     (prom_we)
    );

    rom_slot #(.AW(`MAIN_AW), .DW(`MAIN_DW), .OFFSET(`MAIN_OFFSET)) main_slot_inst (
        .clk (clk), .rst_n (rst_n), .downloading (downloading),
        .cs (main_cs), .addr (main_addr), .fill (slot_fill[0]), .fill_data (fill_data),
        .ok (main_ok), .data (main_data), .req (slot_req[0]), .req_addr (req_addr_main)
    );

    rom_slot #(.AW(`OBJ_AW), .DW(`OBJ_DW), .OFFSET(`OBJ_OFFSET)) obj_slot_inst (
        .clk (clk), .rst_n (rst_n), .downloading (downloading),
        .cs (obj_cs), .addr (obj_addr), .fill (slot_fill[1]), .fill_data (fill_data),
        .ok (obj_ok), .data (obj_data), .req (slot_req[1]), .req_addr (req_addr_obj)
    );

    rom_slot #(.AW(`CHAR_AW), .DW(`CHAR_DW), .OFFSET(`CHAR_OFFSET)) char_slot_inst (
        .clk (clk), .rst_n (rst_n), .downloading (downloading),
        .cs (char_cs), .addr (char_addr), .fill (slot_fill[2]), .fill_data (fill_data),
        .ok (char_ok), .data (char_data), .req (slot_req[2]), .req_addr (req_addr_char)
    );

    rom_arbiter rom_arbiter_inst (
        .clk           (clk),
        .rst_n         (rst_n),
        .downloading   (downloading),
        .req           (slot_req),
        .req_addr_main (req_addr_main),
        .req_addr_obj  (req_addr_obj),
        .req_addr_char (req_addr_char),
        .sdram_ack     (sdram_ack),
        .data_rdy      (data_rdy),
        .data_read     (data_read),
        .fill          (slot_fill),
        .fill_data     (fill_data),
        .sdram_req     (sdram_req),
        .sdram_addr    (sdram_addr)
    );

endmodule

// ==== tests/tb_arcade_rom.sv ====
// ####################
// Testbench for arcade_rom_top
// SDRAM model, ROM download, slot reads,
// cache hits and read priority
// ####################
`timescale 1ns/1ps
`include "arcade_consts.svh"

module tb_arcade_rom import arcade_pkg::*; ();

    localparam int TIMEOUT      = 100;    // Cycles per wait
    localparam int FLAG_PROG_WE = 0;      // Slot ok flags follow as 1 + slot

    logic        clk;
    logic        rst_n;
    logic        downloading;
    logic        ioctl_wr;
    ioctl_addr_t ioctl_addr;
    byte_t       ioctl_data;
    sdram_addr_t prog_addr;
    byte_t       prog_data;
    prog_mask_t  prog_mask;
    logic        prog_we;
    logic        prom_we;
    logic        sdram_req;
    sdram_addr_t sdram_addr;
    logic        sdram_ack;
    logic        data_rdy;
    sdram_word_t data_read;
    logic        pxl2_cen;
    logic        pxl_cen;
    logic        main_cs;
    main_addr_t  main_addr;
    byte_t       main_data;
    logic        main_ok;
    logic        char_cs;
    char_addr_t  char_addr;
    byte_t       char_data;
    logic        char_ok;
    logic        obj_cs;
    obj_addr_t   obj_addr;
    half_t       obj_data;
    logic        obj_ok;

    byte_t       dl_bytes[int unsigned];    // Mirror of the download stream
    half_t       sdram_mem[int unsigned];
    sdram_addr_t req_addrs[$];              // sdram_addr of every new read
    int          write_acks;
    logic [31:0] stim_rng;
    int unsigned main_start;                // Downloaded block starts in bytes
    int unsigned char_start;
    int unsigned obj_start;

    arcade_rom_top arcade_rom_top_inst (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        return x ^ (x << 5);
    endfunction

    function automatic logic [31:0] next_rand();
        stim_rng = xorshift32(stim_rng);
        return stim_rng;
    endfunction

    function automatic half_t mem_read(input int unsigned a);
        if (sdram_mem.exists(a)) begin
            return sdram_mem[a];
        end
        return half_t'(a ^ (a >> 16));      // Unwritten words
    endfunction

    // Expected slot data for a byte address (half-word address when wide)
    function automatic half_t expected_data(input int unsigned base, input int unsigned addr,
                                            input bit wide);
        int unsigned burst;
        int unsigned b;
        if (wide) begin
            burst = base / 2 + (addr >> 1) * 2;
            b = 2 * (burst + (addr & 1));
            return {dl_bytes[b + 1], dl_bytes[b]};
        end
        burst = base / 2 + (addr >> 2) * 2;
        b = 2 * (burst + ((addr >> 1) & 1)) + (addr & 1);
        return {8'h00, dl_bytes[b]};
    endfunction

    function automatic int unsigned slot_addr(input int slot, input int unsigned off);
        case (slot)
            0:       return main_start + off;
            1:       return char_start + off;
            default: return obj_start / 2 + off % 32;    // Half words
        endcase
    endfunction

    function automatic logic flag(input int which);
        case (which)
            FLAG_PROG_WE: return prog_we;
            1:            return main_ok;
            2:            return char_ok;
            default:      return obj_ok;
        endcase
    endfunction

    task automatic report_error(input string msg);
        $display("%s", msg);
        $display("STATUS: FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic value_error(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        report_error($sformatf("FAILED %s: got 0x%0h, expected 0x%0h", name, got, exp));
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic wait_flag(input int which, input logic level, input string what);
        for (int n = 0; n < TIMEOUT; n++) begin
            next_cycle();
            if (flag(which) == level) return;
        end
        report_error({"timeout while waiting for ", what});
    endtask

    // SDRAM with random latencies for writes and burst reads
    initial begin : sdram_model
        logic [31:0] rng;
        half_t       w;
        sdram_addr_t a;
        rng        = xorshift32(32'h140a_0460);
        write_acks = 0;
        sdram_ack  = 1'b0;
        data_rdy   = 1'b0;
        data_read  = '0;
        forever begin
            next_cycle();
            if (prog_we) begin
                w = mem_read(prog_addr);
                if (!prog_mask[0]) w[7:0] = prog_data;
                if (!prog_mask[1]) w[15:8] = prog_data;
                sdram_mem[prog_addr] = w;
                rng = xorshift32(rng);
                repeat (rng % 4) next_cycle();
                sdram_ack = 1'b1;
                write_acks++;
                next_cycle();
                sdram_ack = 1'b0;
            end else if (sdram_req) begin
                a   = sdram_addr;
                rng = xorshift32(rng);
                repeat (rng % 4) next_cycle();
                sdram_ack = 1'b1;
                next_cycle();
                sdram_ack = 1'b0;
                repeat (1 + rng[15:8] % 5) next_cycle();
                data_read = {mem_read(a + 1), mem_read(a)};   // Even word low
                data_rdy  = 1'b1;
                next_cycle();
                data_rdy  = 1'b0;
            end
        end
    end

    // Compares every served slot read against the reference
    initial begin : compare
        logic  req_seen;
        half_t exp;
        req_seen = 1'b0;
        forever begin
            @(posedge clk);
            #1;
            if (downloading) begin
                assert (!sdram_req) else report_error("SDRAM read requested during the download");
            end
            if (sdram_req && !req_seen) req_addrs.push_back(sdram_addr);
            req_seen = sdram_req;
            if (main_cs && main_ok) begin
                exp = expected_data(`MAIN_BASE, main_addr, 1'b0);
                assert (main_data == exp[7:0]) else value_error("main_data", main_data, exp);
            end
            if (char_cs && char_ok) begin
                exp = expected_data(`CHAR_BASE, char_addr, 1'b0);
                assert (char_data == exp[7:0]) else value_error("char_data", char_data, exp);
            end
            if (obj_cs && obj_ok) begin
                exp = expected_data(`OBJ_BASE, obj_addr, 1'b1);
                assert (obj_data == exp) else value_error("obj_data", obj_data, exp);
            end
        end
    end

    task automatic send_byte(input ioctl_addr_t a, input byte_t d);
        ioctl_addr  = a;
        ioctl_data  = d;
        ioctl_wr    = 1'b1;
        dl_bytes[a] = d;
        next_cycle();
        ioctl_wr    = 1'b0;
    endtask

    task automatic write_rom_byte(input ioctl_addr_t a);
        byte_t      d;
        int         acks;
        prog_mask_t exp_mask;
        d        = byte_t'(next_rand());
        acks     = write_acks;
        exp_mask = a[0] ? 2'b01 : 2'b10;    // Even byte to the low lane
        send_byte(a, d);
        assert (prog_we) else report_error("prog_we did not rise after the strobe");
        assert (prog_addr == a >> 1) else value_error("prog_addr", prog_addr, a >> 1);
        assert (prog_data == d) else value_error("prog_data", prog_data, d);
        assert (prog_mask == exp_mask) else value_error("prog_mask", prog_mask, exp_mask);
        wait_flag(FLAG_PROG_WE, 1'b0, "prog_we to fall");
        assert (write_acks == acks + 1) else report_error("prog_we fell without an SDRAM ack");
    endtask

    task automatic write_prom_byte(input int unsigned offset);
        byte_t d;
        d = byte_t'(next_rand());
        send_byte(`PROM_BASE + offset, d);
        assert (prom_we) else report_error("prom_we did not pulse for a PROM byte");
        assert (prog_addr == offset) else value_error("prog_addr", prog_addr, offset);
        assert (prog_data == d) else value_error("prog_data", prog_data, d);
        assert (!prog_we) else report_error("prog_we rose for a PROM byte");
        next_cycle();
        assert (!prom_we && !prog_we) else report_error("PROM write lasted more than one cycle");
    endtask

    task automatic drive_slot(input int slot, input logic cs, input int unsigned a);
        case (slot)
            0: begin
                main_cs   = cs;
                main_addr = main_addr_t'(a);
            end
            1: begin
                char_cs   = cs;
                char_addr = char_addr_t'(a);
            end
            default: begin
                obj_cs    = cs;
                obj_addr  = obj_addr_t'(a);
            end
        endcase
    endtask

    task automatic read_slot(input int slot, input int unsigned a);
        drive_slot(slot, 1'b1, a);
        wait_flag(slot + 1, 1'b1, "slot ok");
        drive_slot(slot, 1'b0, a);
    endtask

    initial begin : stimulus
        int          last2;
        int          last1;
        int          n2;
        int          n1;
        int          mark;
        int          slot;
        int unsigned off[3];
        int unsigned ma;
        int unsigned exp_word;
        rst_n       = 1'b0;
        downloading = 1'b0;
        ioctl_wr    = 1'b0;
        ioctl_addr  = '0;
        ioctl_data  = '0;
        // Selected through reset while the caches are still empty
        drive_slot(0, 1'b1, 0);
        drive_slot(1, 1'b1, 0);
        drive_slot(2, 1'b1, 0);
        stim_rng    = 32'h140a_0460;
        repeat (3) @(posedge clk);
        #2;
        rst_n = 1'b1;
        next_cycle();
        assert (!prog_we && !prom_we && !sdram_req && !pxl2_cen && !pxl_cen
                && !main_ok && !char_ok && !obj_ok)
            else report_error("an output is not low after reset");
        drive_slot(0, 1'b0, 0);
        drive_slot(1, 1'b0, 0);
        drive_slot(2, 1'b0, 0);

        // Clock enable spacing
        last2 = -1;
        last1 = -1;
        n2    = 0;
        n1    = 0;
        for (int i = 0; i < 64; i++) begin
            next_cycle();
            assert (!pxl_cen || pxl2_cen) else report_error("pxl_cen high without pxl2_cen");
            if (pxl2_cen) begin
                assert ((last2 < 0) ? (i < 4) : (i - last2 == 4))
                    else report_error("pxl2_cen is not high one cycle in four");
                last2 = i;
                n2++;
            end
            if (pxl_cen) begin
                assert ((last1 < 0) ? (i < 8) : (i - last1 == 8))
                    else report_error("pxl_cen is not high one cycle in eight");
                last1 = i;
                n1++;
            end
        end
        assert (n2 == 16 && n1 == 8) else report_error("wrong number of clock enables");

        main_start  = next_rand() & 32'h3_FFC0;
        char_start  = next_rand() & 32'h0_FFC0;
        obj_start   = next_rand() & 32'h3_FFC0;
        downloading = 1'b1;
        // Slots keep asking during the download
        drive_slot(0, 1'b1, main_start);
        drive_slot(1, 1'b1, char_start);
        drive_slot(2, 1'b1, obj_start / 2);
        for (int i = 0; i < 64; i++) begin
            write_rom_byte(`MAIN_BASE + main_start + i);
            write_rom_byte(`CHAR_BASE + char_start + i);
            write_rom_byte(`OBJ_BASE + obj_start + i);
        end
        for (int i = 0; i < 8; i++) begin
            write_prom_byte(next_rand() % `PROM_SIZE);
        end
        send_byte(`PROM_BASE + `PROM_SIZE + (next_rand() & 32'hFF), 8'h5A);
        assert (!prog_we && !prom_we) else report_error("byte past the PROM was not ignored");
        drive_slot(0, 1'b0, 0);
        drive_slot(1, 1'b0, 0);
        drive_slot(2, 1'b0, 0);
        downloading = 1'b0;
        next_cycle();

        for (int i = 0; i < 24; i++) begin
            slot = next_rand() % 3;
            read_slot(slot, slot_addr(slot, next_rand() % 64));
        end

        // Repeat reads hit the cache
        for (int s = 0; s < 3; s++) begin
            off[s] = next_rand() % 64;
            read_slot(s, slot_addr(s, off[s]));
            mark = req_addrs.size();
            next_cycle();
            drive_slot(s, 1'b1, slot_addr(s, off[s]));
            #1;
            assert (flag(s + 1)) else report_error("cache hit did not give ok with cs");
            next_cycle();
            next_cycle();
            assert (req_addrs.size() == mark) else report_error("cache hit issued an SDRAM read");
            drive_slot(s, 1'b0, slot_addr(s, off[s]));
        end

        // Main and object miss together and main goes first
        ma       = slot_addr(0, off[0] ^ 4);
        exp_word = ((`MAIN_BASE >> 1) + (ma >> 1)) & ~32'd1;
        mark     = req_addrs.size();
        drive_slot(0, 1'b1, ma);
        drive_slot(2, 1'b1, slot_addr(2, off[2] ^ 2));
        wait_flag(1, 1'b1, "main_ok");
        wait_flag(3, 1'b1, "obj_ok");
        assert (req_addrs.size() == mark + 2) else report_error("expected two SDRAM reads");
        assert (req_addrs[mark] == exp_word)
            else value_error("sdram_addr", req_addrs[mark], exp_word);
        drive_slot(0, 1'b0, ma);
        drive_slot(2, 1'b0, 0);
        next_cycle();

        $display("STATUS: PASS");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/arcade_pkg.sv
logic/cen_gen.sv
logic/rom_download.sv
logic/rom_slot.sv
logic/rom_arbiter.sv
logic/arcade_rom_top.sv
tests/tb_arcade_rom.sv

// ==== Bender.yml ====
package:
  name: arcade_rom

sources:
  - include_dirs:
      - logic
    files:
      - logic/arcade_pkg.sv
      - logic/cen_gen.sv
      - logic/rom_download.sv
      - logic/rom_slot.sv
      - logic/rom_arbiter.sv
      - logic/arcade_rom_top.sv
  - target: test
    include_dirs:
      - logic
    files:
      - tests/tb_arcade_rom.sv
